/* Makefile */
# Verilator build and run for the NIM+ control core testbench

VERILATOR ?= verilator
TOP       ?= nim_plus_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+include
hw/nim_plus_pkg.sv
hw/param_regs.sv
hw/dac_bit_timer.sv
hw/dac_shift_reg.sv
hw/dac_ctrl_fsm.sv
hw/output_router.sv
hw/nim_plus_top.sv
dv/nim_plus_tb.sv

/* dv/nim_plus_tb.sv */
`timescale 1ns/1ps
`include "nim_plus_defines.svh"

module nim_plus_tb;

   localparam int ACK_TIMEOUT  = 20;    // Cycles to wait for an ack
   localparam int SYNC_TIMEOUT = 50;    // Cycles from command to nsync low
   localparam int IDLE_TIMEOUT = 200;   // Status reads before busy must clear

   localparam logic [`NIM_ADDR_W-1:0] A_DAC_DATA = nim_plus_pkg::REG_DAC_DATA;
   localparam logic [`NIM_ADDR_W-1:0] A_DAC_CMD  = nim_plus_pkg::REG_DAC_CMD;
   localparam logic [`NIM_ADDR_W-1:0] A_MUX0     = nim_plus_pkg::REG_MUX0;
   localparam logic [`NIM_ADDR_W-1:0] A_UNMAPPED = 7'd100;

   logic                    clk_160;
   logic                    arst_n;
   logic                    wr;
   logic                    rd;
   logic [`NIM_ADDR_W-1:0]  addr;
   nim_plus_pkg::reg_word_t wr_data;
   logic                    wr_ack;
   logic                    rd_ack;
   nim_plus_pkg::reg_word_t rd_data;
   logic [7:0]              nim_in;
   logic [3:0]              lvds_in;
   logic [`NIM_N_OUT-1:0]   nim_out;
   logic                    dac_ser_clk;
   logic                    dac_nsync;
   logic                    dac_din;

   int seed = 32'h6d83_1ff6;
   int err_count;
   int test_num;
   int test_fail;
   int test_errs;   // Errors before the running test

   nim_plus_pkg::dac_word_t frames [$];   // Completed DAC frames
   nim_plus_pkg::dac_word_t cap_word;
   int                      cap_bits;
   logic                    sclk_q;
   logic                    nsync_q;

   nim_plus_pkg::reg_word_t rdv;
   nim_plus_pkg::reg_word_t wv [5];
   nim_plus_pkg::reg_word_t frame_a;
   logic [31:0]             sels;       // Four packed selections

   nim_plus_top nim_plus_top_inst
   (
      .clk_160     (clk_160),
      .arst_n      (arst_n),
      .wr          (wr),
      .rd          (rd),
      .addr        (addr),
      .wr_data     (wr_data),
      .wr_ack      (wr_ack),
      .rd_ack      (rd_ack),
      .rd_data     (rd_data),
      .nim_in      (nim_in),
      .lvds_in     (lvds_in),
      .nim_out     (nim_out),
      .dac_ser_clk (dac_ser_clk),
      .dac_nsync   (dac_nsync),
      .dac_din     (dac_din)
   );

   always #4 clk_160 = ~clk_160;   // 125 MHz stand-in for clk_160

   // Expected NIM outputs, NIM inputs at 0..7, LVDS at 8..11, else low
   function automatic logic [3:0] ref_route(input logic [7:0] ni, input logic [3:0] li,
                                            input logic [31:0] s);
      logic [3:0] r;
      logic [7:0] idx;
      for (int i = 0; i < 4; i++)
      begin
         idx = s[8*i +: 8];
         if (idx < 8)
            r[i] = ni[idx[2:0]];
         else if (idx < 12)
            r[i] = li[idx[1:0]];   // 8..11 map to LVDS 0..3
         else
            r[i] = 1'b0;
      end
      return r;
   endfunction

   // Frame that goes out for a REG_DAC_DATA word
   function automatic nim_plus_pkg::dac_word_t ref_frame(input nim_plus_pkg::reg_word_t w);
      return w[15:0];
   endfunction

   function automatic nim_plus_pkg::reg_word_t rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   task automatic check_word(input string name, input nim_plus_pkg::reg_word_t got,
                             input nim_plus_pkg::reg_word_t exp);
      if (got !== exp)
      begin
         $display("error: %s got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_dac(input string name, input nim_plus_pkg::dac_word_t got,
                            input nim_plus_pkg::dac_word_t exp);
      if (got !== exp)
      begin
         $display("error: %s got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_out(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp)
      begin
         $display("error: %s got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   // Bus tasks start and end on a falling edge
   task automatic bus_write(input logic [`NIM_ADDR_W-1:0] a, input nim_plus_pkg::reg_word_t d);
      int n;
      n       = 0;
      addr    = a;
      wr_data = d;
      wr      = 1'b1;
      @(negedge clk_160);
      wr = 1'b0;
      while (!wr_ack && n < ACK_TIMEOUT)
      begin
         @(negedge clk_160);
         n++;
      end
      if (!wr_ack)
      begin
         $display("write to address 0x%h was never acknowledged", a);
         err_count++;
      end
   endtask

   task automatic bus_read(input logic [`NIM_ADDR_W-1:0] a, output nim_plus_pkg::reg_word_t d);
      int n;
      n    = 0;
      addr = a;
      rd   = 1'b1;
      @(negedge clk_160);
      rd = 1'b0;
      while (!rd_ack && n < ACK_TIMEOUT)
      begin
         @(negedge clk_160);
         n++;
      end
      if (!rd_ack)
      begin
         $display("read of address 0x%h was never acknowledged", a);
         err_count++;
      end
      d = rd_data;
   endtask

   task automatic wait_nsync_low();
      int n;
      n = 0;
      while (dac_nsync && n < SYNC_TIMEOUT)
      begin
         @(negedge clk_160);
         n++;
      end
      if (dac_nsync)
      begin
         $display("DAC transfer did not start after the command");
         err_count++;
      end
   endtask

   // First serial clock fall, frame now shifting
   task automatic wait_sclk_low();
      int n;
      n = 0;
      while (dac_ser_clk && n < SYNC_TIMEOUT)
      begin
         @(negedge clk_160);
         n++;
      end
      if (dac_ser_clk)
      begin
         $display("DAC serial clock never fell after the frame started");
         err_count++;
      end
   endtask

   // Polls the busy flag in REG_DAC_CMD
   task automatic wait_dac_idle();
      nim_plus_pkg::reg_word_t s;
      int n;
      n = 0;
      bus_read(A_DAC_CMD, s);
      while (s[8] && n < IDLE_TIMEOUT)
      begin
         bus_read(A_DAC_CMD, s);
         n++;
      end
      if (s[8])
      begin
         $display("DAC busy flag never cleared");
         err_count++;
      end
   endtask

   task automatic check_one_frame(input nim_plus_pkg::reg_word_t w);
      if (frames.size() != 1)
      begin
         $display("expected one DAC frame but captured %0d", frames.size());
         err_count++;
      end
      else
         check_dac("dac_din frame", frames.pop_front(), ref_frame(w));
      frames.delete();
   endtask

   task automatic end_test(input string name);
      test_num++;
      if (err_count != test_errs)
      begin
         test_fail++;
         $display("test %0d %s: FAILED with %0d errors", test_num, name, err_count - test_errs);
      end
      else
         $display("test %0d %s: ok", test_num, name);
      test_errs = err_count;
   endtask

   // Serial capture, sampled mid clk_160 cycle
   always @(negedge clk_160)
   begin
      if (arst_n)
      begin
         if (sclk_q && !dac_ser_clk && !dac_nsync)   // DAC samples on the fall
         begin
            cap_word = {cap_word[14:0], dac_din};
            cap_bits++;
         end
         if (!nsync_q && dac_nsync)   // End of frame
         begin
            if (cap_bits != 16)
            begin
               $display("DAC frame had %0d clock falls instead of 16", cap_bits);
               err_count++;
            end
            frames.push_back(cap_word);
            cap_bits = 0;
         end
      end
      sclk_q  = dac_ser_clk;
      nsync_q = dac_nsync;
   end

   initial
   begin
      clk_160 = 1'b0;
      arst_n  = 1'b0;
      wr      = 1'b0;
      rd      = 1'b0;
      addr    = '0;
      wr_data = '0;
      nim_in  = '0;
      lvds_in = '0;
      sclk_q  = 1'b1;
      nsync_q = 1'b1;
      repeat (4) @(posedge clk_160);
      @(negedge clk_160);
      arst_n = 1'b1;

      // Defaults, outputs follow NIM inputs 0..3
      for (int i = 0; i < 4; i++)
      begin
         bus_read(A_MUX0 + 7'(i), rdv);
         check_word("rd_data mux", rdv, 64'(i));
      end
      bus_read(A_DAC_CMD, rdv);
      check_word("rd_data dac_cmd", rdv, '0);
      nim_in  = 8'($random(seed));
      lvds_in = 4'($random(seed));
      @(negedge clk_160);
      check_out("nim_out", nim_out, nim_in[3:0]);
      end_test("reset defaults");

      for (int i = 0; i < 5; i++)
         wv[i] = rand_word();
      bus_write(A_DAC_DATA, wv[0]);
      for (int i = 0; i < 4; i++)
         bus_write(A_MUX0 + 7'(i), wv[i+1]);
      bus_read(A_DAC_DATA, rdv);
      check_word("rd_data dac_data", rdv, wv[0]);
      for (int i = 0; i < 4; i++)
      begin
         bus_read(A_MUX0 + 7'(i), rdv);
         check_word("rd_data mux", rdv, wv[i+1]);
      end
      bus_write(A_UNMAPPED, rand_word());
      bus_read(A_UNMAPPED, rdv);
      check_word("rd_data unmapped", rdv, '0);
      end_test("register access");

      for (int k = 0; k < 20; k++)
      begin
         for (int i = 0; i < 4; i++)
         begin
            wv[i]      = rand_word();
            wv[i][7:0] = 8'($random(seed) & 15);   // Covers the out of range codes
            sels[8*i +: 8] = wv[i][7:0];
            bus_write(A_MUX0 + 7'(i), wv[i]);
         end
         nim_in  = 8'($random(seed));
         lvds_in = 4'($random(seed));
         @(negedge clk_160);
         check_out("nim_out", nim_out, ref_route(nim_in, lvds_in, sels));
      end
      end_test("routing");

      frames.delete();
      for (int f = 0; f < 4; f++)
      begin
         wv[0] = rand_word();
         bus_write(A_DAC_DATA, wv[0]);
         bus_write(A_DAC_CMD, 64'h1);
         wait_nsync_low();
         bus_read(A_DAC_CMD, rdv);
         check_word("rd_data dac_cmd mid frame", rdv, 64'h100);
         wait_dac_idle();
         check_one_frame(wv[0]);
      end
      end_test("dac frames");

      // Second command lands while the first frame shifts
      frame_a = rand_word();
      bus_write(A_DAC_DATA, frame_a);
      bus_write(A_DAC_CMD, 64'h1);
      wait_nsync_low();
      wait_sclk_low();
      bus_write(A_DAC_DATA, rand_word());
      bus_write(A_DAC_CMD, 64'h1);
      wait_dac_idle();
      repeat (20) @(negedge clk_160);
      if (!dac_nsync)
      begin
         $display("DAC started a second frame from a command issued while busy");
         err_count++;
      end
      check_one_frame(frame_a);
      end_test("start while busy");

      $display("%0d tests run, %0d failed, %0d errors", test_num, test_fail, err_count);
      if (err_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // Whole run guard
   initial
   begin
      #200000;
      $display("simulation ran past its time limit");
      $display("Test failures found");
      $finish;
   end

endmodule

/* hw/dac_bit_timer.sv */
`timescale 1ns/1ps
`include "nim_plus_defines.svh"

module dac_bit_timer
(
   input  logic clk_160,
   input  logic arst_n,
   input  logic run,
   output logic half_tick,   // Last cycle of each half period
   output logic last_bit     // Both halves of the final bit
);

   localparam int N_BITS = $bits(nim_plus_pkg::dac_word_t);
   localparam int CW     = (`DAC_HALF > 1) ? $clog2(`DAC_HALF) : 1;
   localparam int HW     = $clog2(2 * N_BITS + 1);   // Room for the trailing half

   logic [CW-1:0] cyc_cnt;
   logic [HW-1:0] half_cnt;   // Half periods since run rose

   assign half_tick = run && (cyc_cnt == CW'(`DAC_HALF - 1));
   assign last_bit  = run && ((half_cnt >> 1) == HW'(N_BITS - 1));   // Bit index is half/2

   always_ff @(posedge clk_160 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cyc_cnt  <= '0;
         half_cnt <= '0;
      end
      else if (!run)
      begin
         cyc_cnt  <= '0;   // Restart with every frame
         half_cnt <= '0;
      end
      else if (half_tick)
      begin
         cyc_cnt  <= '0;
         half_cnt <= half_cnt + 1'b1;
      end
      else
      begin
         cyc_cnt <= cyc_cnt + 1'b1;
      end
   end

endmodule

/* hw/dac_ctrl_fsm.sv */
`timescale 1ns/1ps

module dac_ctrl_fsm
(
   input  logic clk_160,
   input  logic arst_n,
   input  logic start,
   input  logic half_tick,
   input  logic last_bit,
   output logic timer_run,
   output logic load,
   output logic shift,
   output logic nsync,
   output logic ser_clk,
   output logic busy
);

   nim_plus_pkg::dac_state_t state;
   nim_plus_pkg::dac_state_t state_nxt;

   always_comb
   begin
      state_nxt = state;
      case (state)
         nim_plus_pkg::DAC_IDLE:
            if (start)
               state_nxt = nim_plus_pkg::DAC_SYNC;
         nim_plus_pkg::DAC_SYNC:
            if (half_tick)
               state_nxt = nim_plus_pkg::DAC_SHIFT;   // First falling edge
         nim_plus_pkg::DAC_SHIFT:
            if (half_tick && !ser_clk && last_bit)
               state_nxt = nim_plus_pkg::DAC_DONE;    // End of last low half
         nim_plus_pkg::DAC_DONE:
            if (half_tick)
               state_nxt = nim_plus_pkg::DAC_IDLE;
         default:
            state_nxt = nim_plus_pkg::DAC_IDLE;
      endcase
   end

   assign busy      = (state != nim_plus_pkg::DAC_IDLE);
   assign timer_run = busy;                                  // Timer clears in idle
   assign load      = (state == nim_plus_pkg::DAC_IDLE) && start;   // Starts while busy dropped
   // Next bit at the end of each low half, none after the last
   assign shift     = (state == nim_plus_pkg::DAC_SHIFT) && half_tick && !ser_clk && !last_bit;

   always_ff @(posedge clk_160 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= nim_plus_pkg::DAC_IDLE;
         nsync   <= 1'b1;
         ser_clk <= 1'b1;   // Idles high
      end
      else
      begin
         state <= state_nxt;
         if (load)
            nsync <= 1'b0;
         else if (state == nim_plus_pkg::DAC_SHIFT && state_nxt == nim_plus_pkg::DAC_DONE)
            nsync <= 1'b1;
         // Toggle per half period, ends high after the last bit
         if (half_tick && (state == nim_plus_pkg::DAC_SYNC || state == nim_plus_pkg::DAC_SHIFT))
            ser_clk <= !ser_clk;
      end
   end

   // Frame framing never escapes the busy window
   a_nsync_busy: assert property (@(posedge clk_160) disable iff (!arst_n) !nsync |-> busy);

   // A start mid frame leaves the framing alone
   a_start_ignored: assert property (@(posedge clk_160) disable iff (!arst_n)
      (start && state == nim_plus_pkg::DAC_SHIFT) |=>
         (state == nim_plus_pkg::DAC_SHIFT && !nsync) ||
         (state == nim_plus_pkg::DAC_DONE && nsync));

endmodule

/* hw/dac_shift_reg.sv */
`timescale 1ns/1ps

module dac_shift_reg
(
   input  logic                    clk_160,
   input  logic                    arst_n,
   input  logic                    load,
   input  logic                    shift,
   input  nim_plus_pkg::dac_word_t word,
   output logic                    din
);

   localparam int W = $bits(nim_plus_pkg::dac_word_t);

   nim_plus_pkg::dac_word_t sreg;

   always_ff @(posedge clk_160 or negedge arst_n)
   begin
      if (!arst_n)
         sreg <= '0;
      else if (load)
         sreg <= word;                      // Frame captured at start
      else if (shift)
         sreg <= {sreg[W-2:0], 1'b0};       // Next bit up to the MSB
   end

   assign din = sreg[W-1];   // MSB first on the wire

endmodule

/* hw/nim_plus_pkg.sv */
`include "nim_plus_defines.svh"

package nim_plus_pkg;

   typedef logic [`NIM_DATA_W-1:0] reg_word_t;  // One host register
   typedef logic [`DAC_BITS-1:0]   dac_word_t;  // One DAC frame
   typedef logic [7:0]             sel_t;       // Output source index

   // Mapped word addresses, anything else reads zero
   typedef enum logic [$clog2(`NIM_N_REG)-1:0]
   {
      REG_CTRL     = 0,
      REG_DAC_DATA = 1,                  // Frame in bits 15:0
      REG_DAC_CMD  = 2,                  // Bit 0 starts a transfer, bit 8 busy
      REG_MUX0     = `NIM_MUX_BASE,
      REG_MUX1     = `NIM_MUX_BASE + 1,
      REG_MUX2     = `NIM_MUX_BASE + 2,
      REG_MUX3     = `NIM_MUX_BASE + 3
   } reg_addr_t;

   // DAC transfer sequencing
   typedef enum logic [1:0]
   {
      DAC_IDLE,
      DAC_SYNC,   // nsync low, high half of the first bit
      DAC_SHIFT,
      DAC_DONE    // nsync back high, hold off one half period
   } dac_state_t;

endpackage

/* hw/nim_plus_top.sv */
`timescale 1ns/1ps
`include "nim_plus_defines.svh"

module nim_plus_top
(
   input  logic                    clk_160,
   input  logic                    arst_n,

   // Host register bus
   input  logic                    wr,
   input  logic                    rd,
   input  logic [`NIM_ADDR_W-1:0]  addr,
   input  nim_plus_pkg::reg_word_t wr_data,
   output logic                    wr_ack,
   output logic                    rd_ack,
   output nim_plus_pkg::reg_word_t rd_data,

   // Front panel
   input  logic [7:0]              nim_in,
   input  logic [3:0]              lvds_in,
   output logic [`NIM_N_OUT-1:0]   nim_out,

   // Threshold DAC
   output logic                    dac_ser_clk,
   output logic                    dac_nsync,
   output logic                    dac_din
);

   logic                    dac_busy;
   logic                    dac_start;
   nim_plus_pkg::dac_word_t dac_word;
   nim_plus_pkg::sel_t      sel0;
   nim_plus_pkg::sel_t      sel1;
   nim_plus_pkg::sel_t      sel2;
   nim_plus_pkg::sel_t      sel3;
   logic                    timer_run;
   logic                    half_tick;
   logic                    last_bit;
   logic                    dac_load;
   logic                    dac_shift;

   param_regs param_regs_inst
   (
      .clk_160   (clk_160),
      .arst_n    (arst_n),
      .wr        (wr),
      .rd        (rd),
      .addr      (addr),
      .wr_data   (wr_data),
      .wr_ack    (wr_ack),
      .rd_ack    (rd_ack),
      .rd_data   (rd_data),
      .dac_busy  (dac_busy),
      .dac_start (dac_start),
      .dac_word  (dac_word),
      .sel0      (sel0),
      .sel1      (sel1),
      .sel2      (sel2),
      .sel3      (sel3)
   );

   output_router output_router_inst
   (
      .clk_160 (clk_160),
      .arst_n  (arst_n),
      .nim_in  (nim_in),
      .lvds_in (lvds_in),
      .sel0    (sel0),
      .sel1    (sel1),
      .sel2    (sel2),
      .sel3    (sel3),
      .nim_out (nim_out)
   );

   dac_ctrl_fsm dac_ctrl_fsm_inst
   (
      .clk_160   (clk_160),
      .arst_n    (arst_n),
      .start     (dac_start),
      .half_tick (half_tick),
      .last_bit  (last_bit),
      .timer_run (timer_run),
      .load      (dac_load),
      .shift     (dac_shift),
      .nsync     (dac_nsync),
      .ser_clk   (dac_ser_clk),
      .busy      (dac_busy)   // Also read back in REG_DAC_CMD
   );

   dac_bit_timer dac_bit_timer_inst
   (
      .clk_160   (clk_160),
      .arst_n    (arst_n),
      .run       (timer_run),
      .half_tick (half_tick),
      .last_bit  (last_bit)
   );

   dac_shift_reg dac_shift_reg_inst
   (
      .clk_160 (clk_160),
      .arst_n  (arst_n),
      .load    (dac_load),
      .shift   (dac_shift),
      .word    (dac_word),
      .din     (dac_din)
   );

endmodule

/* hw/output_router.sv */
`timescale 1ns/1ps
`include "nim_plus_defines.svh"

module output_router
(
   input  logic                   clk_160,
   input  logic                   arst_n,
   input  logic [7:0]             nim_in,
   input  logic [3:0]             lvds_in,
   input  nim_plus_pkg::sel_t     sel0,
   input  nim_plus_pkg::sel_t     sel1,
   input  nim_plus_pkg::sel_t     sel2,
   input  nim_plus_pkg::sel_t     sel3,
   output logic [`NIM_N_OUT-1:0]  nim_out
);

   localparam int IW = $clog2(`NIM_N_SRC);

   logic [`NIM_N_SRC-1:0] src;
   nim_plus_pkg::sel_t    sel [`NIM_N_OUT];
   logic [`NIM_N_OUT-1:0] route;

   assign src     = {lvds_in, nim_in};   // NIM 0..7, LVDS 8..11
   assign sel     = '{sel0, sel1, sel2, sel3};

   always_comb
   begin
      for (int i = 0; i < `NIM_N_OUT; i++)
      begin
         if (sel[i] < `NIM_N_SRC)
            route[i] = src[sel[i][IW-1:0]];
         else
            route[i] = 1'b0;   // Out of range selection
      end
   end

   // One cycle from source to pin
   always_ff @(posedge clk_160 or negedge arst_n)
   begin
      if (!arst_n)
         nim_out <= '0;
      else
         nim_out <= route;
   end

endmodule

/* hw/param_regs.sv */
`timescale 1ns/1ps
`include "nim_plus_defines.svh"

module param_regs
(
   input  logic                    clk_160,
   input  logic                    arst_n,

   input  logic                    wr,
   input  logic                    rd,
   input  logic [`NIM_ADDR_W-1:0]  addr,
   input  nim_plus_pkg::reg_word_t wr_data,
   output logic                    wr_ack,
   output logic                    rd_ack,
   output nim_plus_pkg::reg_word_t rd_data,

   input  logic                    dac_busy,
   output logic                    dac_start,   // One cycle pulse
   output nim_plus_pkg::dac_word_t dac_word,

   output nim_plus_pkg::sel_t      sel0,
   output nim_plus_pkg::sel_t      sel1,
   output nim_plus_pkg::sel_t      sel2,
   output nim_plus_pkg::sel_t      sel3
);

   localparam int SEL_W = $bits(nim_plus_pkg::sel_t);
   localparam int DAC_W = $bits(nim_plus_pkg::dac_word_t);

   nim_plus_pkg::reg_addr_t reg_addr;
   nim_plus_pkg::reg_word_t ctrl_q;                  // Spare control word
   nim_plus_pkg::reg_word_t dac_data_q;
   nim_plus_pkg::reg_word_t mux_q [`NIM_N_OUT];      // Full words, upper bits kept
   nim_plus_pkg::reg_word_t rd_mux;

   assign reg_addr = nim_plus_pkg::reg_addr_t'(addr);

   // Write decode and acks
   always_ff @(posedge clk_160 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ctrl_q     <= '0;
         dac_data_q <= '0;
         for (int i = 0; i < `NIM_N_OUT; i++)
            mux_q[i] <= nim_plus_pkg::reg_word_t'(i);   // Output n follows NIM input n
         dac_start  <= 1'b0;
         wr_ack     <= 1'b0;
         rd_ack     <= 1'b0;
      end
      else
      begin
         wr_ack    <= wr;
         rd_ack    <= rd;
         dac_start <= 1'b0;   // Self clearing
         if (wr)
         begin
            case (reg_addr)
               nim_plus_pkg::REG_CTRL:     ctrl_q     <= wr_data;
               nim_plus_pkg::REG_DAC_DATA: dac_data_q <= wr_data;
               nim_plus_pkg::REG_DAC_CMD:  dac_start  <= wr_data[0];
               nim_plus_pkg::REG_MUX0:     mux_q[0]   <= wr_data;
               nim_plus_pkg::REG_MUX1:     mux_q[1]   <= wr_data;
               nim_plus_pkg::REG_MUX2:     mux_q[2]   <= wr_data;
               nim_plus_pkg::REG_MUX3:     mux_q[3]   <= wr_data;
               default:                    ;          // Unmapped, dropped
            endcase
         end
      end
   end

   // Readback select
   always_comb
   begin
      rd_mux = '0;
      case (reg_addr)
         nim_plus_pkg::REG_CTRL:     rd_mux    = ctrl_q;
         nim_plus_pkg::REG_DAC_DATA: rd_mux    = dac_data_q;
         nim_plus_pkg::REG_DAC_CMD:  rd_mux[8] = dac_busy;   // Command bit reads 0
         nim_plus_pkg::REG_MUX0:     rd_mux    = mux_q[0];
         nim_plus_pkg::REG_MUX1:     rd_mux    = mux_q[1];
         nim_plus_pkg::REG_MUX2:     rd_mux    = mux_q[2];
         nim_plus_pkg::REG_MUX3:     rd_mux    = mux_q[3];
         default:                    rd_mux    = '0;
      endcase
   end

   // Returned with rd_ack
   always_ff @(posedge clk_160)
   begin
      if (rd)
         rd_data <= rd_mux;
   end

   assign dac_word = dac_data_q[DAC_W-1:0];
   assign sel0     = mux_q[0][SEL_W-1:0];
   assign sel1     = mux_q[1][SEL_W-1:0];
   assign sel2     = mux_q[2][SEL_W-1:0];
   assign sel3     = mux_q[3][SEL_W-1:0];

   // Host never reads and writes in the same cycle
   a_no_wr_rd: assert property (@(posedge clk_160) disable iff (!arst_n) !(wr && rd));

endmodule

/* include/nim_plus_defines.svh */
`ifndef NIM_PLUS_DEFINES_SVH
`define NIM_PLUS_DEFINES_SVH

// Host register bus
`define NIM_DATA_W   64   // Register word width
`define NIM_ADDR_W   7    // Word address width
`define NIM_N_REG    128  // Size of the register map

// First output select register, one per NIM output after it
`define NIM_MUX_BASE 60

// Output routing
`define NIM_N_OUT    4    // NIM outputs
`define NIM_N_SRC    12   // 8 NIM inputs then 4 LVDS inputs

// Threshold DAC serial link
`define DAC_BITS     16   // Bits per frame, MSB first
`define DAC_HALF     4    // clk_160 cycles per half period of the serial clock

`endif
